// File: project.f
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/sram_port_if.sv
rtl/sram_array.sv
rtl/axi_write_slave.sv
rtl/axi_read_slave.sv
rtl/sram_axi_slave.sv
tb/tb_sram_axi_slave.sv

// File: rtl/axi_pkg.sv
package axi_pkg;

    localparam int ID_W    = 8;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int LEN_W   = 4;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Burst types
    localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
    localparam logic [BURST_W-1:0] BURST_INCR  = 2'b01;
    localparam logic [BURST_W-1:0] BURST_WRAP  = 2'b10;

    // Response codes
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    localparam logic [SIZE_W-1:0] MAX_SIZE = 3'd2;  // 4 bytes per beat

endpackage

// File: rtl/axi_read_slave.sv
`timescale 1ns/1ps

module axi_read_slave (
    input  logic                          ACLK,
    input  logic                          ARESETn,
    input  logic [axi_pkg::ID_W-1:0]      arid,
    input  logic [axi_pkg::ADDR_W-1:0]    araddr,
    input  logic [axi_pkg::LEN_W-1:0]     arlen,
    input  logic [axi_pkg::SIZE_W-1:0]    arsize,
    input  logic [axi_pkg::BURST_W-1:0]   arburst,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [axi_pkg::ID_W-1:0]      rid,
    output logic [axi_pkg::DATA_W-1:0]    rdata,
    output logic [axi_pkg::RESP_W-1:0]    rresp,
    output logic                          rlast,
    output logic                          rvalid,
    input  logic                          rready,
    sram_port_if.engine                   mem
);
    import axi_pkg::*;
    import sram_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_WAIT,
        R_PRESENT
    } rd_state_t;

    rd_state_t          state_q;
    rd_state_t          state_d;
    logic [ID_W-1:0]    id_q;
    sram_addr_t         addr_q;
    logic [LEN_W-1:0]   len_q;
    logic [LEN_W-1:0]   beat_q;
    logic [SIZE_W-1:0]  size_q;
    logic [BURST_W-1:0] burst_q;
    logic               bad_q;
    logic [DATA_W-1:0]  rdata_q;
    logic [RESP_W-1:0]  rresp_q;
    logic               rlast_q;
    logic [RESP_W-1:0]  beat_resp;
    logic               beat_err;
    logic               ar_hs;
    logic               r_hs;

    assign arready = (state_q == R_IDLE);
    assign rvalid  = (state_q == R_PRESENT);
    assign rid     = id_q;
    assign rdata   = rdata_q;
    assign rresp   = rresp_q;
    assign rlast   = rlast_q;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    always_comb begin
        if (bad_q) begin
            beat_resp = RESP_SLVERR;
        end else if (addr_q.f.region != WIN_BASE) begin
            beat_resp = RESP_DECERR;
        end else begin
            beat_resp = RESP_OKAY;
        end
    end

    assign beat_err = (beat_resp != RESP_OKAY);

    // Held until the array grants it
    assign mem.req   = (state_q == R_REQ) && !beat_err;
    assign mem.we    = '0;
    assign mem.addr  = addr_q.f.word;
    assign mem.wdata = '0;

    always_comb begin
        state_d = state_q;
        case (state_q)
            R_IDLE: begin
                if (ar_hs) begin
                    state_d = R_REQ;
                end
            end
            R_REQ: begin
                if (beat_err) begin
                    state_d = R_PRESENT;  // No access for a failing beat
                end else if (mem.gnt) begin
                    state_d = R_WAIT;
                end
            end
            R_WAIT: begin
                state_d = R_PRESENT;
            end
            R_PRESENT: begin
                if (r_hs) begin
                    state_d = rlast_q ? R_IDLE : R_REQ;
                end
            end
            default: begin
                state_d = R_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= R_IDLE;
            beat_q  <= '0;
            bad_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ar_hs) begin
                beat_q <= '0;
                bad_q  <= (arsize > MAX_SIZE) || (arburst == BURST_WRAP);
            end else if (r_hs) begin
                beat_q <= beat_q + LEN_W'(1);
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            id_q       <= arid;
            addr_q.raw <= araddr;
            len_q      <= arlen;
            size_q     <= arsize;
            burst_q    <= arburst;
        end else if (r_hs && (burst_q != BURST_FIXED)) begin
            addr_q.raw <= addr_q.raw + (ADDR_W'(1) << size_q);
        end
    end

    // Response and data stay put while R is presented
    always_ff @(posedge ACLK) begin
        if (state_q == R_REQ) begin
            rresp_q <= beat_resp;
            rlast_q <= (beat_q == len_q);
            if (beat_err) begin
                rdata_q <= '0;
            end
        end
        if (state_q == R_WAIT) begin
            rdata_q <= mem.rdata;
        end
    end

endmodule

// File: rtl/axi_write_slave.sv
`timescale 1ns/1ps

module axi_write_slave (
    input  logic                          ACLK,
    input  logic                          ARESETn,
    input  logic [axi_pkg::ID_W-1:0]      awid,
    input  logic [axi_pkg::ADDR_W-1:0]    awaddr,
    input  logic [axi_pkg::LEN_W-1:0]     awlen,
    input  logic [axi_pkg::SIZE_W-1:0]    awsize,
    input  logic [axi_pkg::BURST_W-1:0]   awburst,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [axi_pkg::DATA_W-1:0]    wdata,
    input  logic [axi_pkg::STRB_W-1:0]    wstrb,
    input  logic                          wlast,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [axi_pkg::ID_W-1:0]      bid,
    output logic [axi_pkg::RESP_W-1:0]    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    sram_port_if.engine                   mem
);
    import axi_pkg::*;
    import sram_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } wr_state_t;

    wr_state_t          state_q;
    wr_state_t          state_d;
    logic [ID_W-1:0]    id_q;
    sram_addr_t         addr_q;
    logic [LEN_W-1:0]   len_q;
    logic [LEN_W-1:0]   beat_q;
    logic [SIZE_W-1:0]  size_q;
    logic [BURST_W-1:0] burst_q;
    logic               bad_q;   // Size or burst type not supported
    logic [RESP_W-1:0]  resp_q;
    logic               aw_hs;
    logic               w_hs;
    logic               b_hs;
    logic               w_end;
    logic               aw_bad;
    logic               in_win;

    assign awready = (state_q == W_IDLE);
    assign wready  = (state_q == W_DATA) && mem.gnt;
    assign bvalid  = (state_q == W_RESP);
    assign bid     = id_q;
    assign bresp   = resp_q;

    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign b_hs   = bvalid && bready;
    assign w_end  = wlast || (beat_q == len_q);  // Early WLAST also closes
    assign aw_bad = (awsize > MAX_SIZE) || (awburst == BURST_WRAP);
    assign in_win = (addr_q.f.region == WIN_BASE);

    // Beat goes to the SRAM on the W handshake edge
    assign mem.req   = (state_q == W_DATA) && wvalid && !bad_q && in_win;
    assign mem.we    = wstrb;
    assign mem.addr  = addr_q.f.word;
    assign mem.wdata = wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            W_IDLE: begin
                if (aw_hs) begin
                    state_d = W_DATA;
                end
            end
            W_DATA: begin
                if (w_hs && w_end) begin
                    state_d = W_RESP;
                end
            end
            W_RESP: begin
                if (b_hs) begin
                    state_d = W_IDLE;
                end
            end
            default: begin
                state_d = W_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= W_IDLE;
            beat_q  <= '0;
            bad_q   <= 1'b0;
            resp_q  <= RESP_OKAY;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                beat_q <= '0;
                bad_q  <= aw_bad;
                resp_q <= aw_bad ? RESP_SLVERR : RESP_OKAY;
            end else if (w_hs) begin
                beat_q <= beat_q + LEN_W'(1);
                if (!bad_q && !in_win) begin
                    resp_q <= RESP_DECERR;  // Sticky for the rest of the burst
                end
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            id_q       <= awid;
            addr_q.raw <= awaddr;
            len_q      <= awlen;
            size_q     <= awsize;
            burst_q    <= awburst;
        end else if (w_hs && (burst_q != BURST_FIXED)) begin
            addr_q.raw <= addr_q.raw + (ADDR_W'(1) << size_q);
        end
    end

endmodule

// File: rtl/sram_array.sv
`timescale 1ns/1ps

module sram_array (
    input logic         ACLK,
    sram_port_if.mem    wr_port,
    sram_port_if.mem    rd_port
);
    import axi_pkg::*;
    import sram_pkg::*;

    logic [DATA_W-1:0]  mem_q [2**WORD_AW];
    logic [DATA_W-1:0]  rdata_q;
    logic               sel_wr;
    logic               acc_en;
    logic [STRB_W-1:0]  acc_we;
    logic [WORD_AW-1:0] acc_addr;
    logic [DATA_W-1:0]  acc_wdata;

    // Writes always win the single port
    assign wr_port.gnt = 1'b1;
    assign rd_port.gnt = !wr_port.req;

    assign sel_wr    = wr_port.req;
    assign acc_en    = wr_port.req || rd_port.req;
    assign acc_we    = sel_wr ? wr_port.we    : rd_port.we;
    assign acc_addr  = sel_wr ? wr_port.addr  : rd_port.addr;
    assign acc_wdata = sel_wr ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge ACLK) begin
        if (acc_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (acc_we[i]) begin
                    mem_q[acc_addr][8*i +: 8] <= acc_wdata[8*i +: 8];
                end
            end
        end
    end

    // Read data only moves on a granted read
    always_ff @(posedge ACLK) begin
        if (acc_en && !sel_wr) begin
            rdata_q <= mem_q[acc_addr];
        end
    end

    assign wr_port.rdata = rdata_q;
    assign rd_port.rdata = rdata_q;

endmodule

// File: rtl/sram_axi_slave.sv
`timescale 1ns/1ps

module sram_axi_slave (
    input  logic                          ACLK,
    input  logic                          ARESETn,
    // Write address
    input  logic [axi_pkg::ID_W-1:0]      AWID,
    input  logic [axi_pkg::ADDR_W-1:0]    AWADDR,
    input  logic [axi_pkg::LEN_W-1:0]     AWLEN,
    input  logic [axi_pkg::SIZE_W-1:0]    AWSIZE,
    input  logic [axi_pkg::BURST_W-1:0]   AWBURST,
    input  logic                          AWVALID,
    output logic                          AWREADY,
    // Write data
    input  logic [axi_pkg::DATA_W-1:0]    WDATA,
    input  logic [axi_pkg::STRB_W-1:0]    WSTRB,
    input  logic                          WLAST,
    input  logic                          WVALID,
    output logic                          WREADY,
    // Write response
    output logic [axi_pkg::ID_W-1:0]      BID,
    output logic [axi_pkg::RESP_W-1:0]    BRESP,
    output logic                          BVALID,
    input  logic                          BREADY,
    // Read address
    input  logic [axi_pkg::ID_W-1:0]      ARID,
    input  logic [axi_pkg::ADDR_W-1:0]    ARADDR,
    input  logic [axi_pkg::LEN_W-1:0]     ARLEN,
    input  logic [axi_pkg::SIZE_W-1:0]    ARSIZE,
    input  logic [axi_pkg::BURST_W-1:0]   ARBURST,
    input  logic                          ARVALID,
    output logic                          ARREADY,
    // Read data
    output logic [axi_pkg::ID_W-1:0]      RID,
    output logic [axi_pkg::DATA_W-1:0]    RDATA,
    output logic [axi_pkg::RESP_W-1:0]    RRESP,
    output logic                          RLAST,
    output logic                          RVALID,
    input  logic                          RREADY
);

    sram_port_if wr_port ();
    sram_port_if rd_port ();

    axi_write_slave i_axi_write_slave (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awid    (AWID),
        .awaddr  (AWADDR),
        .awlen   (AWLEN),
        .awsize  (AWSIZE),
        .awburst (AWBURST),
        .awvalid (AWVALID),
        .awready (AWREADY),
        .wdata   (WDATA),
        .wstrb   (WSTRB),
        .wlast   (WLAST),
        .wvalid  (WVALID),
        .wready  (WREADY),
        .bid     (BID),
        .bresp   (BRESP),
        .bvalid  (BVALID),
        .bready  (BREADY),
        .mem     (wr_port.engine)
    );

    axi_read_slave i_axi_read_slave (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .arid    (ARID),
        .araddr  (ARADDR),
        .arlen   (ARLEN),
        .arsize  (ARSIZE),
        .arburst (ARBURST),
        .arvalid (ARVALID),
        .arready (ARREADY),
        .rid     (RID),
        .rdata   (RDATA),
        .rresp   (RRESP),
        .rlast   (RLAST),
        .rvalid  (RVALID),
        .rready  (RREADY),
        .mem     (rd_port.engine)
    );

    sram_array i_sram_array (
        .ACLK    (ACLK),
        .wr_port (wr_port.mem),
        .rd_port (rd_port.mem)
    );

endmodule

// File: rtl/sram_pkg.sv
package sram_pkg;

    localparam int WORD_AW  = 14;  // 16K words
    localparam int REGION_W = 16;
    localparam int OFFSET_W = 2;

    localparam logic [REGION_W-1:0] WIN_BASE = 16'h0001;  // Window 0x1_0000 to 0x1_FFFF

    typedef struct packed {
        logic [REGION_W-1:0] region;
        logic [WORD_AW-1:0]  word;
        logic [OFFSET_W-1:0] offset;
    } sram_fields_t;

    // Byte address as seen on the bus, or split into SRAM fields
    typedef union packed {
        logic [REGION_W+WORD_AW+OFFSET_W-1:0] raw;
        sram_fields_t                         f;
    } sram_addr_t;

endpackage

// File: rtl/sram_port_if.sv
`timescale 1ns/1ps

interface sram_port_if;
    import axi_pkg::*;
    import sram_pkg::*;

    logic               req;
    logic [STRB_W-1:0]  we;     // Byte lane enables
    logic [WORD_AW-1:0] addr;   // Word index
    logic [DATA_W-1:0]  wdata;
    logic               gnt;
    logic [DATA_W-1:0]  rdata;  // Valid the cycle after a read access

    modport engine (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport mem (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sram_axi_slave -f project.f -o sim

out=$(./obj_dir/sim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -qx "TEST OK"

// File: tb/tb_sram_axi_slave.sv
`timescale 1ns/1ps

module tb_sram_axi_slave;
    import axi_pkg::*;
    import sram_pkg::*;

    localparam int TIMEOUT = 200;  // Cycles per wait

    logic               ACLK;
    logic               ARESETn;
    logic [ID_W-1:0]    AWID, ARID, BID, RID;
    logic [ADDR_W-1:0]  AWADDR, ARADDR;
    logic [LEN_W-1:0]   AWLEN, ARLEN;
    logic [SIZE_W-1:0]  AWSIZE, ARSIZE;
    logic [BURST_W-1:0] AWBURST, ARBURST;
    logic [DATA_W-1:0]  WDATA, RDATA;
    logic [STRB_W-1:0]  WSTRB;
    logic [RESP_W-1:0]  BRESP, RRESP;
    logic               AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
    logic               ARVALID, ARREADY, RLAST, RVALID, RREADY;

    logic [DATA_W-1:0]  ref_mem [2**WORD_AW];  // Expected SRAM contents by word index
    logic [31:0]        seed = 32'd5;
    int                 mismatches = 0;
    int                 timeouts = 0;
    int                 proto_errs = 0;

    logic               r_hold = 1'b0;
    logic [DATA_W-1:0]  r_data;
    logic [RESP_W-1:0]  r_resp;
    logic               r_last;
    logic               b_hold = 1'b0;
    logic [ID_W-1:0]    b_id;
    logic [RESP_W-1:0]  b_resp;

    sram_axi_slave i_sram_axi_slave (.*);

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] d,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = d[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string chan);
        timeouts++;
        $display("Timeout: the %s channel never completed its handshake", chan);
    endtask

    task automatic init_inputs();
        ARESETn = 1'b0;
        AWID    = '0;
        AWADDR  = '0;
        AWLEN   = '0;
        AWSIZE  = '0;
        AWBURST = '0;
        AWVALID = 1'b0;
        WDATA   = '0;
        WSTRB   = '0;
        WLAST   = 1'b0;
        WVALID  = 1'b0;
        BREADY  = 1'b0;
        ARID    = '0;
        ARADDR  = '0;
        ARLEN   = '0;
        ARSIZE  = '0;
        ARBURST = '0;
        ARVALID = 1'b0;
        RREADY  = 1'b0;
    endtask

    task automatic write_burst(input string name, input logic [ID_W-1:0] id,
                               input logic [ADDR_W-1:0] addr, input int len,
                               input logic [SIZE_W-1:0] size, input logic [BURST_W-1:0] burst,
                               input logic [STRB_W-1:0] strb, input bit stall);
        logic [ADDR_W-1:0] a;
        logic [RESP_W-1:0] exp_resp;
        logic [31:0]       rnd;
        logic [ID_W-1:0]   got_id;
        logic [RESP_W-1:0] got_resp;
        bit                bad;
        bit                hs;
        int                n;
        bad = (size > MAX_SIZE) || (burst == BURST_WRAP);
        exp_resp = bad ? RESP_SLVERR : RESP_OKAY;
        a = addr;
        AWID = id;
        AWADDR = addr;
        AWLEN = LEN_W'(len);
        AWSIZE = size;
        AWBURST = burst;
        AWVALID = 1'b1;
        hs = 1'b0;
        n = 0;
        while (!hs && n < TIMEOUT) begin
            @(posedge ACLK);
            hs = AWREADY;
            n++;
            #1;
        end
        AWVALID = 1'b0;
        if (!hs) begin
            report_timeout("AW");
            return;
        end
        for (int i = 0; i <= len; i++) begin
            WDATA = next_random();
            WSTRB = strb;
            WLAST = (i == len);
            WVALID = 1'b1;
            hs = 1'b0;
            n = 0;
            while (!hs && n < TIMEOUT) begin
                @(posedge ACLK);
                hs = WREADY;
                n++;
                #1;
            end
            if (!hs) begin
                WVALID = 1'b0;
                report_timeout("W");
                return;
            end
            if (!bad && a[31:16] == WIN_BASE) begin
                ref_mem[a[15:2]] = merge_lanes(ref_mem[a[15:2]], WDATA, strb);
            end else if (!bad) begin
                exp_resp = RESP_DECERR;
            end
            if (burst == BURST_INCR) begin
                a = a + (ADDR_W'(1) << size);
            end
        end
        WVALID = 1'b0;
        WLAST = 1'b0;
        hs = 1'b0;
        n = 0;
        while (!hs && n < TIMEOUT) begin
            rnd = next_random();
            BREADY = stall ? rnd[16] : 1'b1;
            @(posedge ACLK);
            hs = BVALID && BREADY;
            got_id = BID;
            got_resp = BRESP;
            n++;
            #1;
        end
        BREADY = 1'b0;
        if (!hs) begin
            report_timeout("B");
            return;
        end
        check({name, " bid"}, 32'(id), 32'(got_id));
        check({name, " bresp"}, 32'(exp_resp), 32'(got_resp));
    endtask

    task automatic read_burst(input string name, input logic [ID_W-1:0] id,
                              input logic [ADDR_W-1:0] addr, input int len,
                              input logic [SIZE_W-1:0] size, input logic [BURST_W-1:0] burst,
                              input bit stall);
        logic [ADDR_W-1:0] a;
        logic [RESP_W-1:0] exp_resp;
        logic [DATA_W-1:0] exp_data;
        logic [31:0]       rnd;
        logic [ID_W-1:0]   got_id;
        logic [DATA_W-1:0] got_data;
        logic [RESP_W-1:0] got_resp;
        logic              got_last;
        bit                bad;
        bit                hs;
        int                n;
        bad = (size > MAX_SIZE) || (burst == BURST_WRAP);
        a = addr;
        ARID = id;
        ARADDR = addr;
        ARLEN = LEN_W'(len);
        ARSIZE = size;
        ARBURST = burst;
        ARVALID = 1'b1;
        hs = 1'b0;
        n = 0;
        while (!hs && n < TIMEOUT) begin
            @(posedge ACLK);
            hs = ARREADY;
            n++;
            #1;
        end
        ARVALID = 1'b0;
        if (!hs) begin
            report_timeout("AR");
            return;
        end
        for (int i = 0; i <= len; i++) begin
            hs = 1'b0;
            n = 0;
            while (!hs && n < TIMEOUT) begin
                rnd = next_random();
                RREADY = stall ? rnd[16] : 1'b1;
                @(posedge ACLK);
                hs = RVALID && RREADY;
                got_id = RID;
                got_data = RDATA;
                got_resp = RRESP;
                got_last = RLAST;
                n++;
                #1;
            end
            RREADY = 1'b0;
            if (!hs) begin
                report_timeout("R");
                return;
            end
            if (bad) begin
                exp_resp = RESP_SLVERR;
            end else if (a[31:16] != WIN_BASE) begin
                exp_resp = RESP_DECERR;
            end else begin
                exp_resp = RESP_OKAY;
            end
            exp_data = (exp_resp == RESP_OKAY) ? ref_mem[a[15:2]] : '0;  // Zero on error
            check($sformatf("%s beat %0d rid", name, i), 32'(id), 32'(got_id));
            check($sformatf("%s beat %0d rdata", name, i), exp_data, got_data);
            check($sformatf("%s beat %0d rresp", name, i), 32'(exp_resp), 32'(got_resp));
            check($sformatf("%s beat %0d rlast", name, i), 32'(i == len), 32'(got_last));
            if (burst == BURST_INCR) begin
                a = a + (ADDR_W'(1) << size);
            end
        end
    endtask

    // A stalled beat or response must hold until accepted
    always @(posedge ACLK) begin
        if (r_hold) begin
            assert (RVALID && RDATA === r_data && RRESP === r_resp && RLAST === r_last) else begin
                proto_errs++;
                $display("R channel dropped or changed its beat while RREADY was low");
            end
        end
        if (b_hold) begin
            assert (BVALID && BID === b_id && BRESP === b_resp) else begin
                proto_errs++;
                $display("B channel dropped or changed its response while BREADY was low");
            end
        end
        r_hold <= RVALID && !RREADY;
        r_data <= RDATA;
        r_resp <= RRESP;
        r_last <= RLAST;
        b_hold <= BVALID && !BREADY;
        b_id   <= BID;
        b_resp <= BRESP;
    end

    initial begin
        init_inputs();
        repeat (3) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(posedge ACLK);
        check("reset state", 32'b11000, 32'({AWREADY, ARREADY, WREADY, BVALID, RVALID}));
        #1;
        // Known contents around every word touched below
        write_burst("fill low", 8'h01, 32'h0001_0000, 15, 3'd2, BURST_INCR, 4'hF, 1'b0);
        write_burst("fill mid", 8'h02, 32'h0001_0100, 15, 3'd2, BURST_INCR, 4'hF, 1'b0);
        write_burst("fill top", 8'h03, 32'h0001_FFC0, 15, 3'd2, BURST_INCR, 4'hF, 1'b0);
        write_burst("single", 8'h11, 32'h0001_0004, 0, 3'd2, BURST_INCR, 4'hF, 1'b0);
        read_burst("single", 8'h22, 32'h0001_0004, 0, 3'd2, BURST_INCR, 1'b0);
        write_burst("strobe full", 8'h31, 32'h0001_0008, 0, 3'd2, BURST_INCR, 4'hF, 1'b0);
        write_burst("strobe low", 8'h32, 32'h0001_0008, 0, 3'd2, BURST_INCR, 4'h1, 1'b0);
        write_burst("strobe high", 8'h33, 32'h0001_0008, 0, 3'd2, BURST_INCR, 4'hC, 1'b0);
        read_burst("strobe", 8'h34, 32'h0001_0008, 0, 3'd2, BURST_INCR, 1'b0);
        write_burst("incr", 8'h41, 32'h0001_0010, 3, 3'd2, BURST_INCR, 4'hF, 1'b0);
        read_burst("incr", 8'h42, 32'h0001_0010, 3, 3'd2, BURST_INCR, 1'b0);
        write_burst("fixed", 8'h51, 32'h0001_0020, 2, 3'd2, BURST_FIXED, 4'hF, 1'b0);
        read_burst("fixed", 8'h52, 32'h0001_001C, 2, 3'd2, BURST_INCR, 1'b0);
        // Out of window, bad size and a burst that leaves the window
        write_burst("decerr", 8'h71, 32'h0000_0100, 0, 3'd2, BURST_INCR, 4'hF, 1'b0);
        read_burst("decerr", 8'h72, 32'h0000_0100, 0, 3'd2, BURST_INCR, 1'b0);
        read_burst("decerr alias", 8'h73, 32'h0001_0100, 0, 3'd2, BURST_INCR, 1'b0);
        write_burst("slverr", 8'h74, 32'h0001_0104, 0, 3'd3, BURST_INCR, 4'hF, 1'b0);
        read_burst("slverr", 8'h75, 32'h0001_0104, 0, 3'd3, BURST_INCR, 1'b0);
        read_burst("slverr target", 8'h76, 32'h0001_0104, 0, 3'd2, BURST_INCR, 1'b0);
        write_burst("edge", 8'h77, 32'h0001_FFFC, 1, 3'd2, BURST_INCR, 4'hF, 1'b0);
        read_burst("edge inside", 8'h78, 32'h0001_FFF8, 1, 3'd2, BURST_INCR, 1'b0);
        read_burst("edge crossing", 8'h79, 32'h0001_FFFC, 1, 3'd2, BURST_INCR, 1'b0);
        fork
            write_burst("overlap", 8'h61, 32'h0001_0040, 7, 3'd2, BURST_INCR, 4'hF, 1'b1);
            read_burst("overlap", 8'h62, 32'h0001_0000, 7, 3'd2, BURST_INCR, 1'b1);
        join
        read_burst("overlap readback", 8'h63, 32'h0001_0040, 7, 3'd2, BURST_INCR, 1'b1);
        $display("Mismatches: %0d, timeouts: %0d, protocol errors: %0d",
                 mismatches, timeouts, proto_errs);
        if (mismatches == 0 && timeouts == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
